/* div_subsystem.f */
+incdir+tests
src/div_pkg.sv
src/div_input_fifo.sv
src/div_core.sv
src/div_unit.sv
src/div_subsystem.sv
tests/div_tb.sv

/* Makefile */
# Verilator build and run for the divide subsystem testbench

TOP = div_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): div_subsystem.f src/*.sv tests/*.sv tests/*.svh
	verilator --binary --timing --assert --top-module $(TOP) -f div_subsystem.f -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f div_subsystem.f

clean:
	rm -rf obj_dir $(LOG)

/* tests/div_tb_vectors.svh */
`ifndef DIV_TB_VECTORS_SVH
`define DIV_TB_VECTORS_SVH

// Columns are rs1, rs2, op, expected rd and the test the entry belongs to
typedef struct packed {
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    div_op_t         op;
    logic [xlen-1:0] rd;
    logic [2:0]      test_id;
} vector_t;

localparam int num_vectors = 25;
localparam int num_tests = 5;

// Entries of one test stay together so each test finishes in one piece
localparam vector_t vectors [num_vectors] = '{
    '{32'hffff_fff9, 32'h0000_0002, div,  32'hffff_fffd, 3'd0}, // -7 / 2 truncates to -3
    '{32'hffff_fff9, 32'h0000_0002, divu, 32'h7fff_fffc, 3'd0},
    '{32'h0000_0007, 32'hffff_fffe, div,  32'hffff_fffd, 3'd0}, // 7 / -2
    '{32'hffff_fff9, 32'hffff_fffe, div,  32'h0000_0003, 3'd0},
    '{32'hdead_beef, 32'h0000_0010, divu, 32'h0dea_dbee, 3'd0},
    '{32'hffff_fff9, 32'h0000_0002, rem,  32'hffff_ffff, 3'd1}, // Remainder keeps the dividend sign
    '{32'h0000_0007, 32'hffff_fffe, rem,  32'h0000_0001, 3'd1},
    '{32'hffff_fff9, 32'hffff_fffe, rem,  32'hffff_ffff, 3'd1},
    '{32'hffff_fff9, 32'h0000_0002, remu, 32'h0000_0001, 3'd1},
    '{32'h0000_0064, 32'h0000_0007, remu, 32'h0000_0002, 3'd1},
    '{32'h1234_5678, 32'h0000_0000, div,  32'hffff_ffff, 3'd2}, // Zero divisor gives all ones
    '{32'hffff_fff9, 32'h0000_0000, div,  32'hffff_ffff, 3'd2},
    '{32'h0000_0005, 32'h0000_0000, divu, 32'hffff_ffff, 3'd2},
    '{32'hffff_fff9, 32'h0000_0000, rem,  32'hffff_fff9, 3'd2}, // Dividend comes back unchanged
    '{32'h1234_5678, 32'h0000_0000, remu, 32'h1234_5678, 3'd2},
    '{32'h8000_0000, 32'hffff_ffff, div,  32'h8000_0000, 3'd3}, // Most negative over -1
    '{32'h8000_0000, 32'hffff_ffff, rem,  32'h0000_0000, 3'd3},
    '{32'h8000_0000, 32'hffff_ffff, divu, 32'h0000_0000, 3'd3},
    '{32'h8000_0000, 32'hffff_ffff, remu, 32'h8000_0000, 3'd3},
    '{32'h0000_03e8, 32'h0000_0003, div,  32'h0000_014d, 3'd4}, // 1000 / 3
    '{32'hffff_fc18, 32'h0000_0003, div,  32'hffff_feb3, 3'd4},
    '{32'hffff_fc18, 32'h0000_0003, rem,  32'hffff_ffff, 3'd4},
    '{32'hffff_ffff, 32'h0000_0001, divu, 32'hffff_ffff, 3'd4},
    '{32'h7fff_ffff, 32'h7fff_ffff, div,  32'h0000_0001, 3'd4},
    '{32'h0000_0003, 32'h0000_0007, remu, 32'h0000_0003, 3'd4}  // Divisor larger than dividend
};

`endif

/* tests/div_tb.sv */
`timescale 1ns/1ps

module div_tb;
    import div_pkg::*;

    `include "div_tb_vectors.svh"

    localparam int clk_period = 8;
    localparam int reset_cycles = 16;
    localparam int timeout_ns = num_vectors * (xlen + 8) * 4 * clk_period;

    // Expected result together with the test it counts toward
    typedef struct packed {
        div_result_t res;
        logic [2:0]  test_id;
    } scoreboard_entry_t;

    logic         clk = 1'b0;
    logic         rst = 1'b1;
    div_request_t request = '0;
    logic         request_valid = 1'b0;
    logic         request_ready;
    div_result_t  result;
    logic         result_valid;
    logic         result_accepted = 1'b0;

    logic [31:0]       lfsr = 32'd65751;
    scoreboard_entry_t expected [$];
    string test_names [num_tests] = '{"signed and unsigned division", "remainder",
                                      "division by zero", "signed overflow", "mixed operands"};
    int    results_seen = 0;
    int    results_checked = 0;
    int    pass_count = 0;
    int    fail_count = 0;
    int    error_count = 0;
    int    test_results = 0;
    int    test_failures = 0;
    logic  saw_full = 1'b0;

    div_subsystem UUT (
        .clk            (clk),
        .rst            (rst),
        .request        (request),
        .request_valid  (request_valid),
        .request_ready  (request_ready),
        .result         (result),
        .result_valid   (result_valid),
        .result_accepted(result_accepted)
    );

    always #(clk_period / 2) clk = ~clk;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit handed out
    function automatic logic random_bit();
        logic out;
        out = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    task automatic check_value(input string name, input logic [xlen-1:0] actual,
                               input logic [xlen-1:0] expect_val);
        if (actual !== expect_val) begin
            $display("[ERROR] %0t ns %s actual 0x%08h expected 0x%08h",
                     $time, name, actual, expect_val);
            error_count++;
        end
    endtask

    // Called when the held result will be taken at the coming rising edge
    task automatic take_result();
        scoreboard_entry_t entry;
        int errors_before;
        logic last_in_test;
        results_seen++; // Every transfer counts, expected or not
        if (expected.size() == 0) begin
            $display("At %0t ns a result with id %0d came back with no request outstanding",
                     $time, result.id);
            error_count++;
            fail_count++;
            return;
        end
        entry = expected.pop_front();
        errors_before = error_count;
        check_value("result.rd", result.rd, entry.res.rd);
        check_value("result.id", xlen'(result.id), xlen'(entry.res.id));
        test_results++;
        if (error_count == errors_before) begin
            pass_count++;
        end else begin
            fail_count++;
            test_failures++;
        end
        if (results_checked == num_vectors - 1)
            last_in_test = 1'b1;
        else
            last_in_test = (vectors[results_checked + 1].test_id != entry.test_id);
        results_checked++;
        if (last_in_test) begin
            $display("Test %0d, %s: %0d results, %0d mismatched", entry.test_id,
                     test_names[entry.test_id], test_results, test_failures);
            test_results = 0;
            test_failures = 0;
        end
    endtask

    // Writeback side with random back-pressure, sampled while outputs are steady
    always @(negedge clk) begin
        result_accepted = random_bit(); // One bit per cycle
        if (!request_ready)
            saw_full = 1'b1; // FIFO filled up behind a held result
        if (result_valid && result_accepted)
            take_result();
    end

    initial begin
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("request_ready", request_ready, 1'b1); // Queue comes out of reset empty
        check_value("result_valid", result_valid, 1'b0);
        for (int i = 0; i < num_vectors; i++) begin
            logic [1:0] idle;
            scoreboard_entry_t entry;
            @(posedge clk); // Previous request, if any, is taken at this edge
            idle = {random_bit(), random_bit()}; // Gap of 0 to 3 cycles
            @(negedge clk);
            request_valid = 1'b0;
            repeat (idle) @(negedge clk);
            request.rs1 = vectors[i].rs1;
            request.rs2 = vectors[i].rs2;
            request.op = vectors[i].op;
            request.id = id_w'(i); // Tags wrap modulo 2^id_w
            request_valid = 1'b1;
            while (!request_ready)
                @(negedge clk);
            entry.res.rd = vectors[i].rd;
            entry.res.id = id_w'(i);
            entry.test_id = vectors[i].test_id;
            expected.push_back(entry); // Taken at the coming rising edge
        end
        @(negedge clk);
        request_valid = 1'b0;
        wait (results_checked >= num_vectors);
        repeat (2 * (xlen + 8)) @(negedge clk); // Room for a duplicate result to show up
        check_value("results_seen", results_seen, num_vectors);
        if (!saw_full) begin
            $display("request_ready never went low, so the full FIFO case was not reached");
            error_count++;
        end
        $display("Summary: %0d results passed, %0d failed, %0d errors",
                 pass_count, fail_count, error_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Watchdog ran out after %0d ns with %0d of %0d results back",
                 timeout_ns, results_checked, num_vectors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* src/div_subsystem.sv */
`timescale 1ns/1ps

// Top level of the divide subsystem
// Request port on one side, writeback port on the other
module div_subsystem (
    input  logic                  clk,
    input  logic                  rst,
    input  div_pkg::div_request_t request,         // Operands, opcode and tag
    input  logic                  request_valid,
    output logic                  request_ready,   // Low while the queue is full
    output div_pkg::div_result_t  result,
    output logic                  result_valid,
    input  logic                  result_accepted  // Writeback takes the held result
);

    // All queueing, dividing and result holding lives in the unit
    div_unit unit (
        .clk            (clk),
        .rst            (rst),
        .request        (request),
        .request_valid  (request_valid),
        .request_ready  (request_ready),
        .result         (result),
        .result_valid   (result_valid),
        .result_accepted(result_accepted)
    );

endmodule

/* src/div_unit.sv */
`timescale 1ns/1ps

// Divide unit with request queue, sign handling and a single result register
module div_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  div_pkg::div_request_t request,
    input  logic                  request_valid,
    output logic                  request_ready,
    output div_pkg::div_result_t  result,
    output logic                  result_valid,
    input  logic                  result_accepted
);
    import div_pkg::*;

    div_request_t stage1; // Request at the FIFO head, the one being divided

    logic fifo_push;
    logic fifo_pop;
    logic fifo_valid;
    logic fifo_full;

    logic start;
    logic ack;
    logic in_progress;
    logic output_ready;
    logic complete;
    logic b_is_zero;

    logic signed_op;
    logic dividend_neg;
    logic divisor_neg;
    logic negate_result;

    logic [xlen-1:0] dividend_mag;
    logic [xlen-1:0] divisor_mag;
    logic [xlen-1:0] quotient;
    logic [xlen-1:0] remainder;
    logic [xlen-1:0] selected;
    logic [xlen-1:0] corrected;

    assign request_ready = ~fifo_full;
    assign fifo_push = request_valid & request_ready;
    assign fifo_pop = ack; // Head leaves when its result is captured

    div_input_fifo #(
        .depth(div_fifo_depth)
    ) input_fifo (
        .clk     (clk),
        .rst     (rst),
        .data_in (request),
        .push    (fifo_push),
        .pop     (fifo_pop),
        .data_out(stage1),
        .valid   (fifo_valid),
        .full    (fifo_full)
    );

    // The output register is free if empty or being drained this cycle
    assign output_ready = ~result_valid | result_accepted;
    assign ack = complete & output_ready;
    assign start = fifo_valid & ~in_progress; // One start per FIFO head

    always_ff @(posedge clk) begin
        if (rst)
            in_progress <= 1'b0;
        else if (start)
            in_progress <= 1'b1;
        else if (ack)
            in_progress <= 1'b0; // Next head may start once the core is idle
    end

    // Operand magnitudes for the unsigned core
    assign signed_op = ~stage1.op[0];
    assign dividend_neg = signed_op & stage1.rs1[xlen-1];
    assign divisor_neg = signed_op & stage1.rs2[xlen-1];
    assign dividend_mag = dividend_neg ? -stage1.rs1 : stage1.rs1;
    assign divisor_mag = divisor_neg ? -stage1.rs2 : stage1.rs2;

    div_core #(
        .width(xlen)
    ) divider (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .ack      (ack),
        .a        (dividend_mag),
        .b        (divisor_mag),
        .q        (quotient),
        .r        (remainder),
        .complete (complete),
        .b_is_zero(b_is_zero)
    );

    always_comb begin
        selected = stage1.op[1] ? remainder : quotient;
        // Remainder follows the dividend sign
        // A zero divisor keeps the all-ones quotient as it is
        if (stage1.op[1])
            negate_result = dividend_neg;
        else
            negate_result = ~b_is_zero & (dividend_neg ^ divisor_neg);
        corrected = negate_result ? -selected : selected; // Overflow case wraps back to 0x80000000
    end

    always_ff @(posedge clk) begin
        if (ack) begin
            result.rd <= corrected;
            result.id <= stage1.id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            result_valid <= 1'b0;
        else if (ack)
            result_valid <= 1'b1; // A new result may replace one accepted in the same cycle
        else if (result_accepted)
            result_valid <= 1'b0;
    end

    // Writeback sees a steady value until it accepts it
    result_held: assert property (@(posedge clk) disable iff (rst)
        (result_valid && !result_accepted) |=> (result_valid && $stable(result)))
        else $error("Result changed before it was accepted");

endmodule

/* src/div_core.sv */
`timescale 1ns/1ps

// Unsigned radix-2 restoring divider, one quotient bit per cycle
module div_core #(
    parameter int width = div_pkg::xlen
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             ack,
    input  logic [width-1:0] a,        // Dividend magnitude
    input  logic [width-1:0] b,        // Divisor magnitude
    output logic [width-1:0] q,
    output logic [width-1:0] r,
    output logic             complete,
    output logic             b_is_zero
);
    localparam int cnt_w = $clog2(width + 1);

    logic [width-1:0] b_r;   // Divisor held for the whole run
    logic [width-1:0] q_r;   // Dividend bits shift out of the top, quotient bits in at the bottom
    logic [width-1:0] pr;    // Partial remainder
    logic [cnt_w-1:0] count;
    logic             running;
    logic [width:0]   shifted;
    logic [width+1:0] diff;
    logic             borrow;

    // Next dividend bit joins the partial remainder before the trial subtract
    assign shifted = {pr, q_r[width-1]};
    assign diff = {1'b0, shifted} - {2'b00, b_r};
    assign borrow = diff[width+1]; // Set when the divisor does not fit

    assign q = q_r;
    assign r = pr;

    // The extra count step past width gives the fixed width+1 cycle latency
    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            complete <= 1'b0;
            count    <= '0;
        end else if (start) begin
            running <= 1'b1;
            count   <= '0;
        end else if (running) begin
            if (count == cnt_w'(width)) begin
                running  <= 1'b0;
                complete <= 1'b1; // Held until the unit takes the result
            end else begin
                count <= count + 1'b1;
            end
        end else if (ack) begin
            complete <= 1'b0; // Back to idle one cycle after ack
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            q_r       <= a;
            b_r       <= b;
            pr        <= '0;
            b_is_zero <= (b == '0);
        end else if (running && count != cnt_w'(width)) begin
            // With a zero divisor every subtract succeeds, so q goes all ones and r ends at a
            if (!borrow)
                pr <= diff[width-1:0];
            else
                pr <= shifted[width-1:0];
            q_r <= {q_r[width-2:0], ~borrow};
        end
    end

    // The unit must wait for idle before it starts the next division
    start_when_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !(running || complete))
        else $error("Divider started while busy");

    ack_without_complete: assert property (@(posedge clk) disable iff (rst)
        ack |-> complete)
        else $error("Divider ack without complete");

endmodule

/* src/div_input_fifo.sv */
`timescale 1ns/1ps

// Small circular buffer holding divide requests until the divider takes them
module div_input_fifo #(
    parameter int depth = div_pkg::div_fifo_depth
) (
    input  logic                 clk,
    input  logic                 rst,
    input  div_pkg::div_request_t data_in,
    input  logic                 push,
    input  logic                 pop,
    output div_pkg::div_request_t data_out,
    output logic                 valid,
    output logic                 full
);
    import div_pkg::*;

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1); // Count has to reach depth itself

    div_request_t mem [depth];

    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;

    // Pointers wrap explicitly so a depth that is not a power of two works too
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign data_out = mem[rd_ptr]; // Head is visible without a read strobe
    assign valid = (count != '0);
    assign full = (count == cnt_w'(depth));

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= data_in; // Storage carries no reset
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            // Simultaneous push and pop leave the occupancy unchanged
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A full buffer only takes a new entry when the head leaves in the same cycle
    push_when_full: assert property (@(posedge clk) disable iff (rst)
        (push && full) |-> pop)
        else $error("FIFO push while full without a pop");

    pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> valid)
        else $error("FIFO pop while empty");

endmodule

/* src/div_pkg.sv */
// Shared widths, opcode encoding and payload types for the divide unit
package div_pkg;

    // Operand and result width
    localparam int xlen = 32;

    localparam int id_w = 4; // Instruction tag carried through to writeback

    // Requests that can wait ahead of the divider
    localparam int div_fifo_depth = 4;

    // Opcode follows the low two funct3 bits of the RISC-V M extension
    // Bit 0 marks an unsigned op, bit 1 selects the remainder
    typedef enum logic [1:0] {
        div  = 2'd0,
        divu = 2'd1,
        rem  = 2'd2,
        remu = 2'd3
    } div_op_t;

    // One queued divide request, 70 bits
    typedef struct packed {
        logic [xlen-1:0] rs1; // Dividend
        logic [xlen-1:0] rs2; // Divisor
        div_op_t         op;
        logic [id_w-1:0] id;
    } div_request_t;

    // Value handed to writeback, 36 bits
    typedef struct packed {
        logic [xlen-1:0] rd;
        logic [id_w-1:0] id; // Tag of the request that produced rd
    } div_result_t;

endpackage
